/* lsu_cfg.svh */
//////////////////////////////
// Global sizing for the load-store unit
// Only 32-bit data with 4 byte lanes is supported
// LSU_DEPTH must be at least 1
//////////////////////////////

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Width of a byte address on the core and bus side
`define LSU_ADDR_W 32

// Width of one data word on the core and bus side
`define LSU_DATA_W 32

// Maximum number of bus transfers that may be granted
// but still waiting for their response
`define LSU_DEPTH 2

`endif

/* obi_pkg.sv */
//////////////////////////////
// Bus-side types for the data bus
// One address phase carries one word-aligned transfer
//////////////////////////////

`include "lsu_cfg.svh"

package obi_pkg;

  // One address phase as driven by the master
  // The address is always word aligned
  // Byte enables select the active lanes of wdata
  // For a read the write data is don't care but still driven
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic                   we;
    logic [3:0]             be;
    logic [`LSU_DATA_W-1:0] wdata;
  } obi_req_t;

endpackage

/* lsu_pkg.sv */
//////////////////////////////
// Core-side types of the load-store unit
// Sizes above one word are not encoded
//////////////////////////////

`include "lsu_cfg.svh"

package lsu_pkg;

  // Access size as given by the core
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  // One access accepted from the core and held in the operation queue
  typedef struct packed {
    logic                   we;
    lsu_size_e              size;
    logic                   sign;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_op_t;

  // Bookkeeping for one granted bus transfer
  // The response side needs it to align and merge the returned word
  typedef struct packed {
    logic      is_load;
    logic [1:0] offset;
    lsu_size_e size;
    logic      sign;
    logic      first;
    logic      last;
  } lsu_rsp_info_t;

endpackage

/* obi_if.sv */
//////////////////////////////
// Data bus between the splitter, the merger and the top ports
// Responses return in order and never in the grant cycle
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

interface obi_if
  import obi_pkg::*;
();

  // Address phase handshake and its payload
  logic     req;
  logic     gnt;
  obi_req_t payload;

  // Response phase with one rvalid pulse per granted transfer
  logic                   rvalid;
  logic [`LSU_DATA_W-1:0] rdata;

  // Request side of the unit
  modport master (output req, output payload, input gnt);

  // Response side of the unit
  modport resp (input rvalid, input rdata);

  // Slave view used to reach the pins of the top level
  modport bus (input req, input payload, output gnt, output rvalid, output rdata);

endinterface

/* lsu_fifo.sv */
//////////////////////////////
// Synchronous FIFO with a generic payload
// Push when full and pop when empty are dropped
// Read data is valid only while not empty
//////////////////////////////

`timescale 1ns/1ps

module lsu_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  // A depth of one still needs a one bit pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at DEPTH and not at a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Occupancy is unchanged when both happen in one cycle
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* lsu_req_split.sv */
//////////////////////////////
// Turns queued accesses into word-aligned bus transfers
// A word-crossing access takes two transfers in a row
// Outstanding transfers are limited by the info queue
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_req_split
  import lsu_pkg::*;
  import obi_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  lsu_op_t       op_i,
  input  logic          op_empty_i,
  output logic          op_pop_o,
  obi_if.master         bus,
  output lsu_rsp_info_t info_o,
  output logic          info_push_o,
  input  logic          info_full_i
);

  localparam int AW = `LSU_ADDR_W;
  localparam int DW = `LSU_DATA_W;

  logic            second_q;
  logic [1:0]      offset;
  logic [3:0]      be_base;
  logic [7:0]      be_wide;
  logic [2*DW-1:0] wdata_wide;
  logic [AW-3:0]   word_addr;
  logic            split;
  logic            last;
  logic            fire;
  obi_req_t        req_d;

  //////////////////////////////
  // Lane generation
  //////////////////////////////

  assign offset = op_i.addr[1:0];

  // Byte enables of the access before it is moved to its byte offset
  always_comb begin
    case (op_i.size)
      LSU_SIZE_BYTE: be_base = 4'b0001;
      LSU_SIZE_HALF: be_base = 4'b0011;
      default:       be_base = 4'b1111;
    endcase
  end

  // Shift across two words so the overflow lands in the upper half
  assign be_wide    = {4'b0000, be_base} << offset;
  assign wdata_wide = {{DW{1'b0}}, op_i.wdata} << {offset, 3'b000};

  // Any lane beyond the first word means the access crosses a word
  assign split = |be_wide[7:4];
  assign last  = !split || second_q;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // The second half goes to the next word
  assign word_addr = op_i.addr[AW-1:2] + (AW-2)'(second_q);

  always_comb begin
    req_d.addr  = {word_addr, 2'b00};
    req_d.we    = op_i.we;
    req_d.be    = second_q ? be_wide[7:4] : be_wide[3:0];
    req_d.wdata = second_q ? wdata_wide[2*DW-1:DW] : wdata_wide[DW-1:0];
  end

  // The info queue only drains so req cannot drop before its grant
  assign bus.req     = !op_empty_i && !info_full_i;
  assign bus.payload = req_d;
  assign fire        = bus.req && bus.gnt;

  // The access leaves the queue with the grant of its final transfer
  assign op_pop_o    = fire && last;
  assign info_push_o = fire;

  // What the response side must know about this transfer
  always_comb begin
    info_o.is_load = !op_i.we;
    info_o.offset  = offset;
    info_o.size    = op_i.size;
    info_o.sign    = op_i.sign;
    info_o.first   = split && !second_q;
    info_o.last    = last;
  end

  // Set after the first half of a split is granted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (fire) begin
      second_q <= !last;
    end
  end

endmodule

/* lsu_rsp_merge.sv */
//////////////////////////////
// Collects bus responses and builds the load result
// Expects exactly one info entry per response
// Store responses are dropped
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_rsp_merge
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  obi_if.resp                    bus,
  input  lsu_rsp_info_t          info_i,
  output logic                   info_pop_o,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  localparam int DW = `LSU_DATA_W;

  // A split always starts at offset one or more so byte 0 is never needed
  logic [DW-9:0]   hold_q;
  logic            pend_q;
  logic [2*DW-1:0] merged;
  logic [2*DW-1:0] shifted;
  logic [DW-1:0]   aligned;

  // Every response retires the oldest transfer
  assign info_pop_o = bus.rvalid;

  // Place the held upper bytes below the new word when a split is pending
  assign merged  = pend_q ? {bus.rdata, hold_q, 8'h00} : {{DW{1'b0}}, bus.rdata};
  assign shifted = merged >> {info_i.offset, 3'b000};
  assign aligned = shifted[DW-1:0];

  // Extend by size and sign flag
  always_comb begin
    case (info_i.size)
      LSU_SIZE_BYTE: rdata_o = {{(DW-8){info_i.sign & aligned[7]}}, aligned[7:0]};
      LSU_SIZE_HALF: rdata_o = {{(DW-16){info_i.sign & aligned[15]}}, aligned[15:0]};
      default:       rdata_o = aligned;
    endcase
  end

  // One pulse per load, on its last transfer only
  assign rvalid_o = bus.rvalid && info_i.last && info_i.is_load;

  // Marks that the next response completes a split
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (bus.rvalid) begin
      pend_q <= info_i.first;
    end
  end

  // Upper bytes of the first half
  always_ff @(posedge clk) begin
    if (bus.rvalid && info_i.first) begin
      hold_q <= bus.rdata[DW-1:8];
    end
  end

endmodule

/* lsu_top.sv */
//////////////////////////////
// Load-store unit top level
// Core side uses valid/ready, bus side uses req/gnt and rvalid
// Stores give no response to the core
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Core request
  input  logic                   valid_i,
  output logic                   ready_o,
  input  logic                   we_i,
  input  lsu_size_e              size_i,
  input  logic                   sign_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  // Core response
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   busy_o,
  // Data bus
  output logic                   obi_req_o,
  input  logic                   obi_gnt_i,
  output logic [`LSU_ADDR_W-1:0] obi_addr_o,
  output logic                   obi_we_o,
  output logic [3:0]             obi_be_o,
  output logic [`LSU_DATA_W-1:0] obi_wdata_o,
  input  logic                   obi_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] obi_rdata_i
);

  lsu_op_t       op_in;
  lsu_op_t       op_out;
  logic          op_push;
  logic          op_pop;
  logic          op_full;
  logic          op_empty;
  lsu_rsp_info_t info_in;
  lsu_rsp_info_t info_out;
  logic          info_push;
  logic          info_pop;
  logic          info_full;
  logic          info_empty;

  obi_if i_obi ();

  // Core handshake
  assign op_in   = '{we: we_i, size: size_i, sign: sign_i, addr: addr_i, wdata: wdata_i};
  assign ready_o = !op_full;
  assign op_push = valid_i && ready_o;
  assign busy_o  = !op_empty || !info_empty;

  // Bus pins
  assign obi_req_o    = i_obi.req;
  assign obi_addr_o   = i_obi.payload.addr;
  assign obi_we_o     = i_obi.payload.we;
  assign obi_be_o     = i_obi.payload.be;
  assign obi_wdata_o  = i_obi.payload.wdata;
  assign i_obi.gnt    = obi_gnt_i;
  assign i_obi.rvalid = obi_rvalid_i;
  assign i_obi.rdata  = obi_rdata_i;

  // Holds one accepted access
  lsu_fifo #(.T(lsu_op_t), .DEPTH(1)) i_op_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (op_push),
    .data_i  (op_in),
    .pop_i   (op_pop),
    .data_o  (op_out),
    .full_o  (op_full),
    .empty_o (op_empty)
  );

  lsu_req_split i_req_split (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (op_out),
    .op_empty_i  (op_empty),
    .op_pop_o    (op_pop),
    .bus         (i_obi.master),
    .info_o      (info_in),
    .info_push_o (info_push),
    .info_full_i (info_full)
  );

  // One entry per outstanding transfer
  lsu_fifo #(.T(lsu_rsp_info_t), .DEPTH(`LSU_DEPTH)) i_info_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (info_push),
    .data_i  (info_in),
    .pop_i   (info_pop),
    .data_o  (info_out),
    .full_o  (info_full),
    .empty_o (info_empty)
  );

  lsu_rsp_merge i_rsp_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (i_obi.resp),
    .info_i     (info_out),
    .info_pop_o (info_pop),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o)
  );

endmodule

/* lsu_asserts.sv */
//////////////////////////////
// Bus and counter checks for the load-store unit
// Needs the info_in signal of lsu_top for the split check
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lsu_asserts
  import lsu_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   obi_req_o,
  input logic                   obi_gnt_i,
  input logic [`LSU_ADDR_W-1:0] obi_addr_o,
  input logic                   obi_we_o,
  input logic [3:0]             obi_be_o,
  input logic [`LSU_DATA_W-1:0] obi_wdata_o,
  input logic                   obi_rvalid_i,
  input logic                   busy_o,
  input lsu_rsp_info_t          info_in
);

  logic                   fire;
  logic [3:0]             outstanding_q;
  logic                   split_pend_q;
  logic [`LSU_ADDR_W-1:0] split_addr_q;

  assign fire = obi_req_o && obi_gnt_i;

  // Granted transfers still waiting for their response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      case ({fire, obi_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // Remembers the address of a granted first half
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_pend_q <= 1'b0;
      split_addr_q <= '0;
    end else if (fire) begin
      split_pend_q <= info_in.first;
      split_addr_q <= obi_addr_o;
    end
  end

  a_depth : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= 4'(`LSU_DEPTH))
    else $error("outstanding transfers exceed the limit");

  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> outstanding_q != '0)
    else $error("rvalid with no transfer outstanding");

  a_known : assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o |-> !$isunknown({obi_addr_o, obi_we_o, obi_be_o, obi_wdata_o}))
    else $error("unknown value in the address phase");

  a_stable : assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=>
      obi_req_o && $stable({obi_addr_o, obi_we_o, obi_be_o, obi_wdata_o}))
    else $error("address phase changed before grant");

  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q != '0 |-> busy_o)
    else $error("busy_o low with transfers outstanding");

  // The second half must follow its first half directly on the next word
  a_split_order : assert property (@(posedge clk) disable iff (!rst_n)
    fire && split_pend_q |-> obi_addr_o == split_addr_q + `LSU_ADDR_W'(4))
    else $error("second half of a split is not at the next word");

endmodule

bind lsu_top lsu_asserts i_lsu_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .obi_req_o    (obi_req_o),
  .obi_gnt_i    (obi_gnt_i),
  .obi_addr_o   (obi_addr_o),
  .obi_we_o     (obi_we_o),
  .obi_be_o     (obi_be_o),
  .obi_wdata_o  (obi_wdata_o),
  .obi_rvalid_i (obi_rvalid_i),
  .busy_o       (busy_o),
  .info_in      (info_in)
);

/* tb_lsu.sv */
//////////////////////////////
// Testbench for the load-store unit
// Runs from the project root, where it reads lsu_stimulus.txt
// The bus model decodes address bits 9:2 and keeps 256 words
//////////////////////////////

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module tb_lsu
  import lsu_pkg::*;
();

  localparam int MAX_LINES = 64;
  localparam int TIMEOUT   = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   valid_i;
  logic                   ready_o;
  logic                   we_i;
  lsu_size_e              size_i;
  logic                   sign_i;
  logic [`LSU_ADDR_W-1:0] addr_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic                   rvalid_o;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic                   busy_o;
  logic                   obi_req_o;
  logic                   obi_gnt_i;
  logic [`LSU_ADDR_W-1:0] obi_addr_o;
  logic                   obi_we_o;
  logic [3:0]             obi_be_o;
  logic [`LSU_DATA_W-1:0] obi_wdata_o;
  logic                   obi_rvalid_i;
  logic [`LSU_DATA_W-1:0] obi_rdata_i;

  // Six hex columns per line as described at the head of the stimulus file
  logic [31:0] stim [0:511];

  // Expected load results in request order
  logic [31:0] exp_arr [0:63];
  string       name_arr [0:63];
  int          load_count;
  int          rsp_count;

  lsu_top i_lsu_top (.*);

  // 32-bit xorshift step for memory fill, grants and response delays
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Called at a falling edge; the access is taken at the next rising edge
  task automatic send_line(input int line);
    int          waited;
    logic [31:0] op;
    logic [31:0] addr;
    waited = 0;
    op     = stim[9'(6 * line)];
    addr   = stim[9'(6 * line + 3)];
    // ready_o only depends on flops, so it is stable here
    while (!ready_o) begin
      valid_i = 1'b0;
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout: ready_o stayed low before stimulus line %0d", line + 1);
        stop_on_failure();
      end
    end
    valid_i = 1'b1;
    we_i    = op[0];
    size_i  = lsu_size_e'(stim[9'(6 * line + 1)][1:0]);
    sign_i  = stim[9'(6 * line + 2)][0];
    addr_i  = addr;
    wdata_i = stim[9'(6 * line + 4)];
    if (!op[0]) begin
      exp_arr[load_count[5:0]]  = stim[9'(6 * line + 5)];
      name_arr[load_count[5:0]] = $sformatf("line %0d load at %h", line + 1, addr);
      load_count++;
    end
    @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  // Grants and responses are decided at the falling edge and act at the next rising edge
  initial begin
    logic [31:0] mem [256];
    logic [31:0] rsp_data_q [$];
    int          rsp_due_q [$];
    logic [31:0] rng;
    logic [31:0] mask;
    logic [7:0]  idx;
    int          cycle;
    int          dly;
    obi_gnt_i    = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_rdata_i  = '0;
    cycle        = 0;
    rng          = 32'h9da9;
    // Fill mixes the word address into each random word
    for (int i = 0; i < 256; i++) begin
      rng         = xorshift(rng);
      mem[i[7:0]] = rng ^ {i[7:0], 16'h0000, i[7:0]};
    end
    forever begin
      @(negedge clk);
      // An undriven reset counts as reset so the random sequence starts after it
      if (rst_n !== 1'b1) begin
        obi_gnt_i    = 1'b0;
        obi_rvalid_i = 1'b0;
      end else begin
        cycle++;
        rng       = xorshift(rng);
        obi_gnt_i = (rng[1:0] != 2'b00);
        // The address phase cannot change before the next rising edge
        if (obi_gnt_i && obi_req_o) begin
          idx = obi_addr_o[9:2];
          if (obi_we_o) begin
            mask     = {{8{obi_be_o[3]}}, {8{obi_be_o[2]}}, {8{obi_be_o[1]}}, {8{obi_be_o[0]}}};
            mem[idx] = (mem[idx] & ~mask) | (obi_wdata_o & mask);
          end
          dly = 1 + int'(rng[9:8]) % 3;
          rsp_data_q.push_back(mem[idx]);
          rsp_due_q.push_back(cycle + dly);
        end
        // At most one response per cycle, oldest first
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
          obi_rvalid_i = 1'b1;
          obi_rdata_i  = rsp_data_q.pop_front();
          void'(rsp_due_q.pop_front());
        end else begin
          obi_rvalid_i = 1'b0;
        end
      end
    end
  end

  // Load results are compared in the order of the requests
  always @(posedge clk) begin
    if (rst_n && rvalid_o) begin
      if (rsp_count >= load_count) begin
        $display("Unexpected rvalid_o with no load pending");
        stop_on_failure();
      end else begin
        check_value(name_arr[rsp_count[5:0]], exp_arr[rsp_count[5:0]], rdata_o);
        rsp_count++;
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int line;
    int waited;
    rst_n      = 1'b0;
    valid_i    = 1'b0;
    we_i       = 1'b0;
    size_i     = LSU_SIZE_WORD;
    sign_i     = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    load_count = 0;
    rsp_count  = 0;
    // An all-ones operation column marks the end of the file
    for (int i = 0; i < 512; i++) begin
      stim[i[8:0]] = '1;
    end
    $readmemh("lsu_stimulus.txt", stim);
    // Ten rising edges with reset low, release on the falling edge after them
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    line = 0;
    while (line < MAX_LINES && stim[9'(6 * line)] != '1) begin
      send_line(line);
      line++;
    end
    valid_i = 1'b0;
    if (line == 0) begin
      $display("No stimulus lines were read from lsu_stimulus.txt");
      stop_on_failure();
    end
    waited = 0;
    while (rsp_count < load_count) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout: %0d of %0d load responses arrived", rsp_count, load_count);
        stop_on_failure();
      end
    end
    // Let store responses drain before checking the idle state
    repeat (20) @(negedge clk);
    check_value("idle busy_o", 32'd0, 32'(busy_o));
    check_value("idle obi_req_o", 32'd0, 32'(obi_req_o));
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* lsu_stimulus.txt */
// Columns: we (1 store), size (0 byte 1 half 2 word), sign, address, write data,
// expected load result (ignored for stores). All values are hex.
1 2 0 00000040 11223344 00000000
1 2 0 00000044 8899aabb 00000000
1 2 0 00000048 f0e1d2c3 00000000
0 2 0 00000040 00000000 11223344
0 1 0 00000042 00000000 00001122
0 1 1 00000046 00000000 ffff8899
0 0 0 00000045 00000000 000000aa
0 0 1 00000045 00000000 ffffffaa
0 0 1 00000043 00000000 00000011
0 2 0 00000041 00000000 bb112233
0 2 0 00000043 00000000 99aabb11
0 1 0 00000047 00000000 0000c388
0 1 1 00000047 00000000 ffffc388
0 2 0 00000046 00000000 d2c38899
1 0 0 00000049 0000005a 00000000
1 1 0 00000042 0000beef 00000000
0 2 0 00000048 00000000 f0e15ac3
0 2 0 00000040 00000000 beef3344
1 2 0 0000004b cafef00d 00000000
0 2 0 00000048 00000000 0de15ac3
0 1 0 0000004c 00000000 0000fef0
0 0 1 0000004e 00000000 ffffffca
0 2 0 0000004a 00000000 fef00de1

/* files.f */
+incdir+.
obi_pkg.sv
lsu_pkg.sv
obi_if.sv
lsu_fifo.sv
lsu_req_split.sv
lsu_rsp_merge.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

/* Makefile */
TOP = tb_lsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
